//--- design/imuldiv_pkg.sv
// shared widths, function codes and message types for the multiply/divide unit
// fn code 2'b11 is not defined and the top steers it to the divider as unsigned
package imuldiv_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------

  // operand width
  localparam int data_w = 32;
  // one result bit per iteration
  localparam int iter_n = 32;
  // counter must reach iter_n itself, so one bit wider than log2
  localparam int cnt_w  = 6;

  // ------------------------------------------------------------
  // function codes
  // ------------------------------------------------------------

  typedef enum logic [1:0] {
    // signed 32x32 -> 64 multiply
    fn_mul  = 2'd0,
    // signed divide and remainder
    fn_div  = 2'd1,
    // unsigned divide and remainder
    fn_divu = 2'd2
  } imuldiv_fn_e;

  // ------------------------------------------------------------
  // messages
  // ------------------------------------------------------------

  // request, a is multiplicand or dividend, b is multiplier or divisor
  typedef struct packed {
    imuldiv_fn_e       fn;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
  } imuldiv_req_t;

  // divide view of the result word, remainder in the upper half
  typedef struct packed {
    logic [data_w-1:0] rem;
    logic [data_w-1:0] quot;
  } imuldiv_qr_t;

  // one 64-bit word, read as product or as remainder/quotient
  typedef union packed {
    logic signed [2*data_w-1:0] prod;
    imuldiv_qr_t                qr;
  } imuldiv_result_u;

  // response, fn echoes the request so the caller knows the view
  typedef struct packed {
    imuldiv_fn_e     fn;
    imuldiv_result_u result;
  } imuldiv_resp_t;

endpackage

//--- design/imuldiv_mul_iterative.sv
// signed 32x32 shift-and-add multiply on operand magnitudes, sign fixed at the output
// resp_val rises 33 cycles after accept; one item deep, no early termination
`timescale 1ns/1ps

module imuldiv_mul_iterative
  import imuldiv_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              req_val,
  output logic              req_rdy,
  input  logic [data_w-1:0] a,
  input  logic [data_w-1:0] b,
  output logic              resp_val,
  input  logic              resp_rdy,
  output imuldiv_result_u   result
);

  typedef enum logic [1:0] {st_idle, st_calc, st_done} state_e;

  state_e             state_q;
  logic [cnt_w-1:0]   count_q;
  logic               last_cnt;
  logic               req_go;
  logic               resp_go;

  // datapath steering from the controller
  logic               op_en;
  logic               op_sel;
  logic               acc_en;
  logic               acc_sel;

  // datapath registers
  logic [2*data_w-1:0] mcand_q;
  logic [data_w-1:0]   mplier_q;
  logic [2*data_w-1:0] acc_q;
  logic                sign_q;

  logic [data_w-1:0]   mag_a;
  logic [data_w-1:0]   mag_b;
  logic [2*data_w-1:0] mcand_nxt;
  logic [data_w-1:0]   mplier_nxt;
  logic [2*data_w-1:0] acc_nxt;

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------

  assign req_go   = req_val & req_rdy;
  assign resp_go  = resp_val & resp_rdy;
  // counts 0..31 are iterations, count 32 is the closing calc cycle
  assign last_cnt = (count_q == cnt_w'(iter_n));

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
      count_q <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          if (req_go) begin
            state_q <= st_calc;
            count_q <= '0;
          end
        end
        st_calc: begin
          if (last_cnt) begin
            state_q <= st_done;
          end else begin
            count_q <= count_q + cnt_w'(1);
          end
        end
        st_done: begin
          // hold the product until the consumer takes it
          if (resp_go) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    op_en    = 1'b0;
    op_sel   = 1'b0;
    acc_en   = 1'b0;
    acc_sel  = 1'b0;
    case (state_q)
      st_idle: begin
        req_rdy = 1'b1;
        // load magnitudes and clear accumulator on accept
        op_en   = req_val;
        acc_en  = req_val;
      end
      st_calc: begin
        op_en   = ~last_cnt;
        op_sel  = 1'b1;
        // add only when the current multiplier bit is set
        acc_en  = ~last_cnt & mplier_q[0];
        acc_sel = 1'b1;
      end
      st_done: resp_val = 1'b1;
      default: ;
    endcase
  end

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------

  assign mag_a = a[data_w-1] ? -a : a;
  assign mag_b = b[data_w-1] ? -b : b;

  // multiplicand moves left, multiplier moves right
  assign mcand_nxt  = op_sel ? (mcand_q << 1) : {{data_w{1'b0}}, mag_a};
  assign mplier_nxt = op_sel ? (mplier_q >> 1) : mag_b;
  assign acc_nxt    = acc_sel ? (acc_q + mcand_q) : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      mcand_q  <= '0;
      mplier_q <= '0;
      acc_q    <= '0;
      sign_q   <= 1'b0;
    end else begin
      if (op_en) begin
        mcand_q  <= mcand_nxt;
        mplier_q <= mplier_nxt;
      end
      // product sign captured once, at the load
      if (op_en && !op_sel) begin
        sign_q <= a[data_w-1] ^ b[data_w-1];
      end
      if (acc_en) begin
        acc_q <= acc_nxt;
      end
    end
  end

  // negate the magnitude product when exactly one operand was negative
  always_comb begin
    result.prod = sign_q ? -acc_q : acc_q;
  end

endmodule

//--- design/imuldiv_div_iterative.sv
// restoring divide, signed or unsigned, quotient truncates toward zero
// divide by zero gives all-ones quotient and remainder equal to the dividend
// resp_val rises 33 cycles after accept; one item deep
`timescale 1ns/1ps

module imuldiv_div_iterative
  import imuldiv_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              req_val,
  output logic              req_rdy,
  input  logic              signed_op,
  input  logic [data_w-1:0] a,
  input  logic [data_w-1:0] b,
  output logic              resp_val,
  input  logic              resp_rdy,
  output imuldiv_result_u   result
);

  typedef enum logic [1:0] {st_idle, st_calc, st_done} state_e;

  state_e             state_q;
  logic [cnt_w-1:0]   count_q;
  logic               last_cnt;
  logic               req_go;
  logic               resp_go;

  // datapath steering from the controller
  logic               rq_en;
  logic               rq_sel;

  // {remainder, quotient} shift register and divisor
  logic [2*data_w-1:0] rq_q;
  logic [data_w-1:0]   dvsr_q;
  // result fixups recorded on accept
  logic                neg_quot_q;
  logic                neg_rem_q;
  logic                div_zero_q;

  logic [data_w-1:0]   mag_a;
  logic [data_w-1:0]   mag_b;
  logic [2*data_w-1:0] rq_shift;
  logic [data_w:0]     diff;
  logic [2*data_w-1:0] rq_step;
  logic [2*data_w-1:0] rq_nxt;
  logic [data_w-1:0]   quot_raw;
  logic [data_w-1:0]   rem_raw;

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------

  assign req_go   = req_val & req_rdy;
  assign resp_go  = resp_val & resp_rdy;
  // same sequence as the multiplier, count 32 closes the calc phase
  assign last_cnt = (count_q == cnt_w'(iter_n));

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
      count_q <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          if (req_go) begin
            state_q <= st_calc;
            count_q <= '0;
          end
        end
        st_calc: begin
          if (last_cnt) begin
            state_q <= st_done;
          end else begin
            count_q <= count_q + cnt_w'(1);
          end
        end
        st_done: begin
          if (resp_go) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    rq_en    = 1'b0;
    rq_sel   = 1'b0;
    case (state_q)
      st_idle: begin
        req_rdy = 1'b1;
        rq_en   = req_val;
      end
      st_calc: begin
        rq_en  = ~last_cnt;
        rq_sel = 1'b1;
      end
      st_done: resp_val = 1'b1;
      default: ;
    endcase
  end

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------

  // magnitudes only in signed mode, raw bits otherwise
  assign mag_a = (signed_op && a[data_w-1]) ? -a : a;
  assign mag_b = (signed_op && b[data_w-1]) ? -b : b;

  assign rq_shift = rq_q << 1;
  // partial remainder is 33 bits after the shift, so keep the bit shifted out
  assign diff = {rq_q[2*data_w-1], rq_shift[2*data_w-1:data_w]} - {1'b0, dvsr_q};

  // restore on a negative difference, else keep it and set the quotient bit
  assign rq_step = diff[data_w] ? rq_shift
                                : {diff[data_w-1:0], rq_shift[data_w-1:1], 1'b1};
  assign rq_nxt  = rq_sel ? rq_step : {{data_w{1'b0}}, mag_a};

  always_ff @(posedge clk) begin
    if (reset) begin
      rq_q       <= '0;
      dvsr_q     <= '0;
      neg_quot_q <= 1'b0;
      neg_rem_q  <= 1'b0;
      div_zero_q <= 1'b0;
    end else begin
      if (rq_en) begin
        rq_q <= rq_nxt;
      end
      if (rq_en && !rq_sel) begin
        dvsr_q     <= mag_b;
        // quotient negative when signs differ, remainder follows the dividend
        neg_quot_q <= signed_op & (a[data_w-1] ^ b[data_w-1]);
        neg_rem_q  <= signed_op & a[data_w-1];
        div_zero_q <= (b == '0);
      end
    end
  end

  assign quot_raw = rq_q[data_w-1:0];
  assign rem_raw  = rq_q[2*data_w-1:data_w];

  // with a zero divisor every step keeps, so the remainder is already the
  // dividend after the sign fix; only the quotient needs forcing
  always_comb begin
    if (div_zero_q) begin
      result.qr.quot = '1;
    end else begin
      result.qr.quot = neg_quot_q ? -quot_raw : quot_raw;
    end
    result.qr.rem = neg_rem_q ? -rem_raw : rem_raw;
  end

endmodule

//--- design/imuldiv_top.sv
// multiply and divide units run side by side, one item in flight per unit
// responses merge with multiplier priority; a presented divide result is held
`timescale 1ns/1ps

module imuldiv_top
  import imuldiv_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  imuldiv_req_t  req,
  input  logic          req_val,
  output logic          req_rdy,
  output imuldiv_resp_t resp,
  output logic          resp_val,
  input  logic          resp_rdy
);

  logic            sel_div;
  logic            signed_op;

  logic            mul_req_val;
  logic            mul_req_rdy;
  logic            mul_resp_val;
  logic            mul_resp_rdy;
  imuldiv_result_u mul_result;

  logic            div_req_val;
  logic            div_req_rdy;
  logic            div_resp_val;
  logic            div_resp_rdy;
  imuldiv_result_u div_result;

  // fn of the divide in flight, echoed on its response
  imuldiv_fn_e     div_fn_q;
  // divider result on the bus and not yet taken
  logic            div_lock_q;
  logic            mul_sel;

  // ------------------------------------------------------------
  // request steering
  // ------------------------------------------------------------

  assign sel_div   = (req.fn != fn_mul);
  assign signed_op = (req.fn == fn_div);

  assign mul_req_val = req_val & ~sel_div;
  assign div_req_val = req_val & sel_div;
  assign req_rdy     = sel_div ? div_req_rdy : mul_req_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      div_fn_q <= fn_div;
    end else if (div_req_val && div_req_rdy) begin
      div_fn_q <= req.fn;
    end
  end

  imuldiv_mul_iterative u_mul (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .a        (req.a),
    .b        (req.b),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .result   (mul_result)
  );

  imuldiv_div_iterative u_div (
    .clk       (clk),
    .reset     (reset),
    .req_val   (div_req_val),
    .req_rdy   (div_req_rdy),
    .signed_op (signed_op),
    .a         (req.a),
    .b         (req.b),
    .resp_val  (div_resp_val),
    .resp_rdy  (div_resp_rdy),
    .result    (div_result)
  );

  // ------------------------------------------------------------
  // response merge
  // ------------------------------------------------------------

  // multiplier wins unless a divide result is already showing, which keeps
  // resp stable while it waits under back-pressure
  assign mul_sel = mul_resp_val & ~div_lock_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      div_lock_q <= 1'b0;
    end else begin
      div_lock_q <= div_resp_val & ~mul_sel & ~resp_rdy;
    end
  end

  assign resp_val     = mul_resp_val | div_resp_val;
  assign mul_resp_rdy = resp_rdy & mul_sel;
  assign div_resp_rdy = resp_rdy & ~mul_sel;

  always_comb begin
    resp.fn     = mul_sel ? fn_mul : div_fn_q;
    resp.result = mul_sel ? mul_result : div_result;
  end

endmodule

//--- tb/imuldiv_chk.sv
// handshake properties on the imuldiv_top ports, bound into every instance
// all but the reset property are off while reset is high
`timescale 1ns/1ps

module imuldiv_chk
  import imuldiv_pkg::*;
(
  input logic          clk,
  input logic          reset,
  input imuldiv_req_t  req,
  input logic          req_val,
  input logic          req_rdy,
  input imuldiv_resp_t resp,
  input logic          resp_val,
  input logic          resp_rdy
);

  // ------------------------------------------------------------
  // request side
  // ------------------------------------------------------------

  // a stalled request stays up and unchanged
  req_hold_a: assert property (@(posedge clk) disable iff (reset)
    req_val && !req_rdy |=> req_val && $stable(req))
    else $error("request dropped or changed while stalled");

  // ------------------------------------------------------------
  // response side
  // ------------------------------------------------------------

  // a refused response is offered again unchanged
  resp_hold_a: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp))
    else $error("response dropped or changed under back-pressure");

  // both units come out of reset idle
  reset_idle_a: assert property (@(posedge clk)
    reset |=> !resp_val)
    else $error("resp_val high in the cycle after reset");

endmodule

bind imuldiv_top imuldiv_chk u_chk (
  .clk      (clk),
  .reset    (reset),
  .req      (req),
  .req_val  (req_val),
  .req_rdy  (req_rdy),
  .resp     (resp),
  .resp_val (resp_val),
  .resp_rdy (resp_rdy)
);

//--- tb/imuldiv_tb.sv
// self-checking testbench for imuldiv_top, random operands from a fixed seed
// expected results come from a behavioral model with one queue per unit
// inputs change 2 ns after the rising edge, outputs are sampled at the falling edge
`timescale 1ns/1ps

module imuldiv_tb
  import imuldiv_pkg::*;
();

  localparam int clk_half   = 20;
  localparam int lat_cycles = 33;
  localparam int wait_max   = 2000;

  logic          clk;
  logic          reset;
  imuldiv_req_t  req;
  logic          req_val;
  logic          req_rdy;
  imuldiv_resp_t resp;
  logic          resp_val;
  logic          resp_rdy;
  logic          rdy_nxt;

  int seed        = 24;
  int cyc         = 0;
  int errors      = 0;
  int checks      = 0;
  int tests       = 0;
  int failed      = 0;
  int last_accept = 0;
  // resp_rdy source, 0 held high, 1 held low, 2 random
  int rdy_mode    = 0;

  // expected responses per unit, oldest first
  imuldiv_resp_t mul_exp_q[$];
  imuldiv_resp_t div_exp_q[$];
  // fn of every response that transferred, in order
  imuldiv_fn_e   fn_log[$];

  imuldiv_top u_dut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #clk_half clk = ~clk;
    end
  end

  // rising edges seen so far
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // consumer ready, chosen mid-cycle and applied after the next edge
  always begin
    @(negedge clk);
    case (rdy_mode)
      1: rdy_nxt = 1'b0;
      2: rdy_nxt = ($random(seed) % 3) != 0;
      default: rdy_nxt = 1'b1;
    endcase
    @(posedge clk);
    #2;
    resp_rdy = rdy_nxt;
  end

  // ------------------------------------------------------------
  // model and checks
  // ------------------------------------------------------------

  // mostly random words with the usual corner values mixed in
  function automatic logic [31:0] pick_operand();
    int sel;
    sel = $random(seed) & 7;
    case (sel)
      0: return 32'h0000_0000;
      1: return 32'hffff_ffff;
      2: return 32'h8000_0000;
      3: return 32'h7fff_ffff;
      default: return $random(seed);
    endcase
  endfunction

  // full signed product, truncating divide, all-ones quotient on zero divisor
  function automatic imuldiv_resp_t expected_resp(input imuldiv_fn_e fn,
                                                  input logic [31:0] a,
                                                  input logic [31:0] b);
    imuldiv_resp_t want;
    longint        sa;
    longint        sb;
    longint        q;
    longint        r;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    want.fn = fn;
    if (fn == fn_mul) begin
      want.result.prod = sa * sb;
    end else if (b == 32'h0) begin
      want.result.qr.quot = '1;
      want.result.qr.rem  = a;
    end else if (fn == fn_div) begin
      // 64-bit arithmetic keeps the overflow case exact before the cut
      q = sa / sb;
      r = sa % sb;
      want.result.qr.quot = q[31:0];
      want.result.qr.rem  = r[31:0];
    end else begin
      want.result.qr.quot = a / b;
      want.result.qr.rem  = a % b;
    end
    return want;
  endfunction

  task automatic compare_word(input string name, input logic [63:0] got,
                              input logic [63:0] want);
    checks++;
    assert (got === want) else begin
      $display("CHECK FAILED %s got %h expected %h at %0t", name, got, want, $time);
      errors++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("TIMEOUT: %s at %0t", what, $time);
    $display("Regression failed");
    $finish;
  endtask

  // response monitor, pops the queue that resp.fn selects
  task automatic take_response();
    imuldiv_resp_t want;
    fn_log.push_back(resp.fn);
    if (resp.fn == fn_mul) begin
      assert (mul_exp_q.size() != 0) else begin
        $display("ERROR: multiply response arrived with no multiply outstanding");
        errors++;
      end
      if (mul_exp_q.size() != 0) begin
        want = mul_exp_q.pop_front();
        compare_word("resp.result.prod", 64'(resp.result.prod), 64'(want.result.prod));
      end
    end else begin
      assert (div_exp_q.size() != 0) else begin
        $display("ERROR: divide response arrived with no divide outstanding");
        errors++;
      end
      if (div_exp_q.size() != 0) begin
        want = div_exp_q.pop_front();
        compare_word("resp.fn", 64'(resp.fn), 64'(want.fn));
        compare_word("resp.result.qr.quot", 64'(resp.result.qr.quot),
                     64'(want.result.qr.quot));
        compare_word("resp.result.qr.rem", 64'(resp.result.qr.rem),
                     64'(want.result.qr.rem));
      end
    end
  endtask

  always @(negedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      take_response();
    end
  end

  // ------------------------------------------------------------
  // stimulus tasks, each starts and ends 2 ns after a rising edge
  // ------------------------------------------------------------

  task automatic send_req(input imuldiv_fn_e fn, input logic [31:0] a,
                          input logic [31:0] b);
    int waited;
    int pending;
    logic accepted;
    waited   = 0;
    accepted = 1'b0;
    req.fn   = fn;
    req.a    = a;
    req.b    = b;
    req_val  = 1'b1;
    while (!accepted) begin
      @(negedge clk);
      pending = (fn == fn_mul) ? mul_exp_q.size() : div_exp_q.size();
      // a unit still holding a response must refuse new work
      if (pending != 0) begin
        compare_word("req_rdy", 64'(req_rdy), 64'd0);
      end
      accepted = req_rdy;
      waited++;
      if (!accepted && waited > wait_max) begin
        abort_run("request was never accepted");
      end
    end
    last_accept = cyc + 1;
    if (fn == fn_mul) begin
      mul_exp_q.push_back(expected_resp(fn, a, b));
    end else begin
      div_exp_q.push_back(expected_resp(fn, a, b));
    end
    @(posedge clk);
    #2;
    req_val = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (mul_exp_q.size() + div_exp_q.size() != 0) begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > wait_max) begin
        abort_run("outstanding responses never came back");
      end
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: FAILED with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic random_ops(input int count, input int fn_mix);
    imuldiv_fn_e fn;
    logic [31:0] a;
    logic [31:0] b;
    repeat (count) begin
      // fn_mix 0 multiply only, 1 divide only, 2 both units
      case (fn_mix == 2 ? ($random(seed) & 3) : fn_mix + 2)
        0: fn = fn_div;
        1: fn = fn_divu;
        2: fn = fn_mul;
        3: fn = ($random(seed) & 1) ? fn_div : fn_divu;
        default: fn = fn_mul;
      endcase
      a = pick_operand();
      b = pick_operand();
      send_req(fn, a, b);
    end
  endtask

  task automatic measure_latency(input imuldiv_fn_e fn);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    send_req(fn, $random(seed), 32'h0000_0007);
    while (!seen) begin
      @(negedge clk);
      seen = resp_val;
      waited++;
      if (!seen && waited > wait_max) begin
        abort_run("resp_val never rose after a single request");
      end
    end
    compare_word("resp_val latency", 64'(cyc - last_accept), 64'(lat_cycles));
    @(posedge clk);
    #2;
    wait_drain();
  endtask

  task automatic run_priority_test();
    int e0;
    int waited;
    e0     = errors;
    waited = 0;
    rdy_mode = 1;
    fn_log.delete();
    send_req(fn_mul, 32'hfff0_1234, 32'h0000_0321);
    send_req(fn_divu, 32'h8765_4321, 32'h0000_0013);
    // both units finish within the fixed 33-cycle latency of the later accept
    while (cyc - last_accept < lat_cycles) begin
      @(negedge clk);
      waited++;
      if (waited > wait_max) begin
        abort_run("cycle count stalled in the priority test");
      end
    end
    compare_word("resp_val", 64'(resp_val), 64'd1);
    compare_word("resp.fn", 64'(resp.fn), 64'(fn_mul));
    @(posedge clk);
    #2;
    rdy_mode = 0;
    wait_drain();
    compare_word("response count", 64'(fn_log.size()), 64'd2);
    if (fn_log.size() == 2) begin
      compare_word("first resp.fn", 64'(fn_log[0]), 64'(fn_mul));
      compare_word("second resp.fn", 64'(fn_log[1]), 64'(fn_divu));
    end
    finish_test("priority", e0);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------

  initial begin
    int e0;
    reset    = 1'b1;
    req      = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;

    e0 = errors;
    @(negedge clk);
    compare_word("req_rdy", 64'(req_rdy), 64'd1);
    compare_word("resp_val", 64'(resp_val), 64'd0);
    @(posedge clk);
    #2;
    finish_test("reset", e0);

    e0 = errors;
    random_ops(40, 0);
    wait_drain();
    finish_test("multiply", e0);

    e0 = errors;
    random_ops(40, 1);
    // most negative over -1 in both modes
    send_req(fn_div, 32'h8000_0000, 32'hffff_ffff);
    send_req(fn_divu, 32'h8000_0000, 32'hffff_ffff);
    wait_drain();
    finish_test("divide", e0);

    e0 = errors;
    repeat (6) begin
      send_req(fn_div, pick_operand(), 32'h0000_0000);
      send_req(fn_divu, pick_operand(), 32'h0000_0000);
    end
    wait_drain();
    finish_test("divide by zero", e0);

    e0 = errors;
    measure_latency(fn_mul);
    measure_latency(fn_div);
    finish_test("latency", e0);

    run_priority_test();

    e0 = errors;
    rdy_mode = 2;
    random_ops(60, 2);
    wait_drain();
    rdy_mode = 0;
    finish_test("back-pressure", e0);

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
    if (errors == 0 && failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- flist.f
design/imuldiv_pkg.sv
design/imuldiv_mul_iterative.sv
design/imuldiv_div_iterative.sv
design/imuldiv_top.sv
tb/imuldiv_chk.sv
tb/imuldiv_tb.sv

//--- run.sh
#!/bin/sh
# compile with Verilator, run, and decide the result from the log

cd "$(dirname "$0")" || exit 1

log=sim.log
bin=obj_dir/Vimuldiv_tb

verilator --binary --timing --assert \
  --top-module imuldiv_tb \
  --Mdir obj_dir \
  -f flist.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"$bin" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed$" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1
